/* spc2wbm.f */
+incdir+common
common/pcx_cpx_pkg.sv
common/wb_bus_pkg.sv
rtl/pcx_capture.sv
rtl/wb_access/wb_access_plan.sv
rtl/wb_access/wb_beat_seq.sv
rtl/cpx_return.sv
rtl/spc2wbm_top.sv
verif/wb_resp_slave.sv
verif/spc2wbm_tb.sv

/* Bender.yml */
package:
  name: spc2wbm

sources:
  - include_dirs:
      - common
    files:
      - common/pcx_cpx_pkg.sv
      - common/wb_bus_pkg.sv
      - rtl/pcx_capture.sv
      - rtl/wb_access/wb_access_plan.sv
      - rtl/wb_access/wb_beat_seq.sv
      - rtl/cpx_return.sv
      - rtl/spc2wbm_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/wb_resp_slave.sv
      - verif/spc2wbm_tb.sv

/* verif/spc2wbm_tb.sv */
// Testbench for the SPC to Wishbone bridge
// Random loads, stores and boot ROM fills, each checked against a reference model
// of the grant handshake, the Wishbone beats and the CPX return packet
`default_nettype none

`include "spc2wbm_cfg.svh"

module spc2wbm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import pcx_cpx_pkg::*;
  import wb_bus_pkg::*;

  localparam int num_requests = 200;
  localparam int max_cycles   = num_requests * 30 + 100;  // Worst request needs under 20
  localparam logic [`WB_DATA_W-1:0] data_key = 64'hc3a5_0f96_1e2d_7b48;
  localparam logic [2:0] small_sizes [4] = '{`SZ_1B, `SZ_2B, `SZ_4B, `SZ_8B};

  logic                  sys_clock;
  logic                  sys_reset;
  logic [`REGION_W-1:0]  spc_req;
  logic                  spc_atom;
  pcx_packet_t           spc_packetout;
  logic [`REGION_W-1:0]  spc_grant;
  logic                  spc_stallreq;
  logic                  spc_ready;
  cpx_packet_t           spc_packetin;
  wb_req_t               wbm_req;
  logic                  wbm_ack;
  logic [`WB_DATA_W-1:0] wbm_data;
  int                    cycle_cnt;

  spc2wbm_top dut_i (
    .sys_clock_i     (sys_clock),
    .sys_reset_i     (sys_reset),
    .spc_req_i       (spc_req),
    .spc_atom_i      (spc_atom),
    .spc_packetout_i (spc_packetout),
    .spc_grant_o     (spc_grant),
    .spc_stallreq_o  (spc_stallreq),
    .spc_ready_o     (spc_ready),
    .spc_packetin_o  (spc_packetin),
    .wbm_req_o       (wbm_req),
    .wbm_ack_i       (wbm_ack),
    .wbm_data_i      (wbm_data)
  );

  wb_resp_slave #(.data_key(data_key)) u_slave (
    .sys_clock_i (sys_clock),
    .sys_reset_i (sys_reset),
    .wbm_req_i   (wbm_req),
    .wbm_ack_o   (wbm_ack),
    .wbm_data_o  (wbm_data)
  );

  always #10 sys_clock = ~sys_clock;  // 20 ns period

  always @(posedge sys_clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles)
      report_failure($sformatf("Timeout: the run did not end within %0d cycles", max_cycles));
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic string wb_text(input wb_req_t w);
    return $sformatf("cyc %b stb %b we %b adr %h dat %h sel %h",
                     w.cyc, w.stb, w.we, w.adr, w.dat, w.sel);
  endfunction

  function automatic string cpx_text(input cpx_packet_t c);
    return $sformatf("v %b type %h miss %b err %b nc %b thr %0d wv %b way %0d bf %b at %b pfl %b data %h",
                     c.valid, c.rtn_type, c.miss, c.err, c.nc, c.thread, c.way_valid, c.way,
                     c.boot_fetch, c.atomic, c.pfl, c.data);
  endfunction

  task automatic check_wb(input wb_req_t exp, input wb_req_t act, input string what);
    if (act !== exp)
      report_failure($sformatf("mismatch at time %0t: %s got %s, expected %s",
                               $time, what, wb_text(act), wb_text(exp)));
  endtask

  task automatic check_cpx(input cpx_packet_t exp, input cpx_packet_t act, input string what);
    if (act !== exp)
      report_failure($sformatf("mismatch at time %0t: %s got %s, expected %s",
                               $time, what, cpx_text(act), cpx_text(exp)));
  endtask

  task automatic check_grant(input logic [`REGION_W-1:0] exp, input logic [`REGION_W-1:0] act,
                             input string what);
    if (act !== exp)
      report_failure($sformatf("mismatch at time %0t: %s got %b, expected %b",
                               $time, what, act, exp));
  endtask

  task automatic check_flag(input logic exp, input logic act, input string what);
    if (act !== exp)
      report_failure($sformatf("mismatch at time %0t: %s got %b, expected %b",
                               $time, what, act, exp));
  endtask

  function automatic int size_bytes(input logic [2:0] size);
    case (size)
      `SZ_1B:  return 1;
      `SZ_2B:  return 2;
      `SZ_4B:  return 4;
      default: return 8;  // 8 and 16 bytes use the whole doubleword
    endcase
  endfunction

  // Naturally aligned lanes holding the access
  function automatic logic [7:0] lane_select(input int nbytes, input logic [2:0] low);
    logic [7:0] sel;
    int         first;
    first = (int'(low) / nbytes) * nbytes;
    for (int b = 0; b < 8; b++)
      sel[b] = (b >= first) && (b < first + nbytes);
    return sel;
  endfunction

  function automatic bit two_beats(input pcx_packet_t pkt);
    return pkt.rq_type == `IMISS_RQ || (pkt.rq_type == `LOAD_RQ && pkt.size == `SZ_16B);
  endfunction

  function automatic wb_req_t expect_beat(input pcx_packet_t pkt,
                                          input logic [`REGION_W-1:0] region, input int beat);
    wb_req_t               w;
    logic [`WB_ADDR_W-1:0] base;
    base      = {region, 19'b0, pkt.addr};
    base[2:0] = 3'b000;  // Doubleword aligned
    w         = '0;
    w.cyc     = 1'b1;
    w.stb     = 1'b1;
    if (beat == 1) begin
      w.adr = base;
      w.we  = (pkt.rq_type == `STORE_RQ);
      w.dat = pkt.data;  // Zero for loads and fills
      w.sel = (pkt.rq_type == `IMISS_RQ) ? lane_select(4, pkt.addr[2:0])
                                         : lane_select(size_bytes(pkt.size), pkt.addr[2:0]);
    end else begin
      w.adr = base | 64'h8;  // Odd doubleword, full read
      w.sel = '1;
    end
    return w;
  endfunction

  function automatic cpx_packet_t expect_return(input pcx_packet_t pkt,
                                                input logic [`REGION_W-1:0] region,
                                                input logic atom);
    cpx_packet_t           c;
    wb_req_t               b1;
    wb_req_t               b2;
    logic [`WB_DATA_W-1:0] d1;
    logic [`WB_DATA_W-1:0] d2;
    b1           = expect_beat(pkt, region, 1);
    b2           = expect_beat(pkt, region, 2);
    d1           = b1.adr ^ data_key;  // Slave read data
    d2           = b2.adr ^ data_key;
    c            = '0;
    c.valid      = 1'b1;
    c.nc         = pkt.nc;
    c.thread     = pkt.thread;
    c.boot_fetch = (region == `REGION_IO);
    c.atomic     = atom;
    case (pkt.rq_type)
      `STORE_RQ: c.rtn_type = `ST_ACK;  // Data stays zero
      `IMISS_RQ: begin
        c.rtn_type = `IFILL_RET;
        c.atomic   = 1'b0;
      end
      default:   c.rtn_type = `LOAD_RET;
    endcase
    if (pkt.rq_type != `STORE_RQ) begin
      if (two_beats(pkt))
        c.data = pkt.addr[3] ? {{`WB_DATA_W{1'b0}}, d2} : {d1, d2};
      else
        c.data = pkt.addr[3] ? {{`WB_DATA_W{1'b0}}, d1} : {d1, {`WB_DATA_W{1'b0}}};
    end
    return c;
  endfunction

  // Called on a falling edge with the bridge idle
  task automatic run_request(input int kind);
    pcx_packet_t          pkt;
    logic [`REGION_W-1:0] region;
    logic                 atom;
    int                   beats;
    int                   nbeats;
    int                   low_cnt;
    logic                 stb_seen;
    logic                 exp_ready;
    pkt        = '0;
    pkt.valid  = 1'b1;
    pkt.cpu_id = $urandom;
    pkt.thread = $urandom;
    pkt.nc     = $urandom;
    pkt.way    = $urandom;
    pkt.addr   = {$urandom, $urandom};
    pkt.size   = small_sizes[$urandom % 4];
    atom       = $urandom;
    region     = 5'b00001 << ($urandom % 4);  // One of the RAM regions
    case (kind)
      0: pkt.rq_type = `LOAD_RQ;
      1: begin
        pkt.rq_type = `LOAD_RQ;
        pkt.size    = `SZ_16B;
      end
      2: begin
        pkt.rq_type = `STORE_RQ;
        pkt.data    = {$urandom, $urandom};
      end
      default: begin
        pkt.rq_type = `IMISS_RQ;
        region      = `REGION_IO;  // Boot ROM fetch
      end
    endcase
    spc_req       = region;
    spc_atom      = atom;
    spc_packetout = pkt;
    @(negedge sys_clock);
    check_flag(1'b1, spc_stallreq, "stall after request");
    check_grant('0, spc_grant, "grant in request cycle");
    spc_req  = '0;
    spc_atom = 1'b0;
    @(negedge sys_clock);  // Packet latched at this edge
    check_grant(region, spc_grant, "grant");
    check_flag(1'b1, spc_stallreq, "stall during grant");
    spc_packetout = '0;
    nbeats        = two_beats(pkt) ? 2 : 1;
    beats         = 0;
    low_cnt       = 0;
    stb_seen      = 1'b0;
    exp_ready     = 1'b0;
    while (!exp_ready) begin
      @(negedge sys_clock);
      check_grant('0, spc_grant, "grant after grant cycle");
      if (wbm_req.stb) begin
        if (!stb_seen)
          beats++;  // Strobe drops between beats
        if (beats > nbeats)
          report_failure($sformatf("mismatch at time %0t: beat %0d of a %0d-beat request",
                                   $time, beats, nbeats));
        check_wb(expect_beat(pkt, region, beats), wbm_req, "wishbone beat");
        low_cnt = 0;
      end else begin
        check_flag(1'b0, wbm_req.cyc, "cycle with strobe low");
        if (beats == nbeats)
          low_cnt++;
      end
      stb_seen  = wbm_req.stb;
      // Done at the last ack edge, ready one edge later
      exp_ready = (low_cnt == 2);
      check_flag(exp_ready, spc_ready, "ready");
      check_flag(!exp_ready, spc_stallreq, "stall until ready");
      if (!exp_ready)
        check_cpx('0, spc_packetin, "packet while not ready");
    end
    check_cpx(expect_return(pkt, region, atom), spc_packetin, "return packet");
  endtask

  initial begin : stimulus
    cpx_packet_t wake;
    void'($urandom(32'h65e9_8dd9));
    sys_clock     = 1'b0;
    sys_reset     = 1'b1;
    spc_req       = '0;
    spc_atom      = 1'b0;
    spc_packetout = '0;
    cycle_cnt     = 0;
    repeat (5) @(negedge sys_clock);
    sys_reset = 1'b0;
    do begin
      @(negedge sys_clock);
      check_grant('0, spc_grant, "grant before wakeup");
      check_flag(1'b0, spc_stallreq, "stall before wakeup");
      check_flag(1'b0, wbm_req.stb, "strobe before wakeup");
    end while (!spc_ready);
    wake          = '0;
    wake.valid    = 1'b1;
    wake.rtn_type = `INT_RET;
    wake.data     = `WAKEUP_DATA;
    check_cpx(wake, spc_packetin, "wakeup packet");
    for (int i = 0; i < num_requests; i++)
      run_request($urandom % 4);  // Load, 16-byte load, store, fill
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/wb_resp_slave.sv */
// Wishbone slave model for the bridge testbench
// Acks each beat after 0 to 3 random cycles
// Read data is the beat address XOR a key, writes answer with zero
`default_nettype none

`include "spc2wbm_cfg.svh"

module wb_resp_slave #(
  parameter logic [`WB_DATA_W-1:0] data_key = '0
) (
  input  wire                      sys_clock_i,
  input  wire                      sys_reset_i,
  input  wire wb_bus_pkg::wb_req_t wbm_req_i,
  output logic                     wbm_ack_o,
  output logic [`WB_DATA_W-1:0]    wbm_data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import wb_bus_pkg::*;

  logic        armed_q;  // Delay already drawn for this beat
  int unsigned left_q;   // Cycles still to wait

  initial begin
    wbm_ack_o  = 1'b0;
    wbm_data_o = '0;
  end

  // Falling edge drive, the bridge samples on the rising edge
  always @(negedge sys_clock_i) begin : respond
    int unsigned wait_n;
    if (sys_reset_i) begin
      wbm_ack_o  <= 1'b0;
      wbm_data_o <= '0;
      armed_q    <= 1'b0;
      left_q     <= 0;
    end else begin
      wbm_ack_o  <= 1'b0;  // Single-cycle ack
      wbm_data_o <= '0;
      if (wbm_req_i.cyc && wbm_req_i.stb && !wbm_ack_o) begin
        wait_n = armed_q ? left_q : ($urandom % 4);  // New beat draws its delay
        if (wait_n == 0) begin
          wbm_ack_o  <= 1'b1;
          wbm_data_o <= wbm_req_i.we ? '0 : (wbm_req_i.adr ^ data_key);
          armed_q    <= 1'b0;
        end else begin
          left_q  <= wait_n - 1;
          armed_q <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/spc2wbm_top.sv */
// SPC to Wishbone master bridge
// PCX requests in, 64-bit Wishbone accesses out, CPX returns back to the core
// One request in flight, held off by the stall request
`default_nettype none

`include "spc2wbm_cfg.svh"

module spc2wbm_top (
  input  wire                         sys_clock_i,
  input  wire                         sys_reset_i,
  input  wire [`REGION_W-1:0]         spc_req_i,
  input  wire                         spc_atom_i,
  input  wire pcx_cpx_pkg::pcx_packet_t spc_packetout_i,
  output logic [`REGION_W-1:0]        spc_grant_o,
  output logic                        spc_stallreq_o,
  output logic                        spc_ready_o,
  output pcx_cpx_pkg::cpx_packet_t    spc_packetin_o,
  output wb_bus_pkg::wb_req_t         wbm_req_o,
  input  wire                         wbm_ack_i,
  input  wire [`WB_DATA_W-1:0]        wbm_data_i
);

  import pcx_cpx_pkg::*;
  import wb_bus_pkg::*;

  pcx_req_t  req;        // Latched request
  logic      start;      // Access kick-off strobe
  wb_plan_t  plan;
  ret_meta_t meta;
  logic      done;       // Last ack seen
  wb_done_t  done_data;

  pcx_capture u_capture (
    .sys_clock_i     (sys_clock_i),
    .sys_reset_i     (sys_reset_i),
    .spc_req_i       (spc_req_i),
    .spc_atom_i      (spc_atom_i),
    .spc_packetout_i (spc_packetout_i),
    .done_i          (done),
    .spc_grant_o     (spc_grant_o),
    .spc_stallreq_o  (spc_stallreq_o),
    .start_o         (start),
    .req_o           (req)
  );

  wb_access_plan u_plan (
    .req_i  (req),
    .plan_o (plan),
    .meta_o (meta)
  );

  wb_beat_seq u_seq (
    .sys_clock_i (sys_clock_i),
    .sys_reset_i (sys_reset_i),
    .start_i     (start),
    .plan_i      (plan),
    .wbm_ack_i   (wbm_ack_i),
    .wbm_data_i  (wbm_data_i),
    .wbm_req_o   (wbm_req_o),
    .done_o      (done),
    .done_data_o (done_data)
  );

  cpx_return u_return (
    .sys_clock_i    (sys_clock_i),
    .sys_reset_i    (sys_reset_i),
    .done_i         (done),
    .done_data_i    (done_data),
    .meta_i         (meta),
    .spc_ready_o    (spc_ready_o),
    .spc_packetin_o (spc_packetin_o)
  );

endmodule

`default_nettype wire

/* rtl/cpx_return.sv */
// CPX return path
// Sends the wakeup packet once after reset, then one return packet per access
// Packet output reads zero when ready is low
`default_nettype none

`include "spc2wbm_cfg.svh"

module cpx_return (
  input  wire                           sys_clock_i,
  input  wire                           sys_reset_i,
  input  wire                           done_i,
  input  wire wb_bus_pkg::wb_done_t     done_data_i,
  input  wire pcx_cpx_pkg::ret_meta_t   meta_i,
  output logic                          spc_ready_o,
  output pcx_cpx_pkg::cpx_packet_t      spc_packetin_o
);

  import pcx_cpx_pkg::*;

  logic        wake_pend_q;  // Wakeup not yet sent
  cpx_packet_t wake_pkt;
  cpx_packet_t ret_pkt;

  // Interrupt return with the wakeup code, all else zero
  always_comb begin
    wake_pkt          = '0;
    wake_pkt.valid    = 1'b1;
    wake_pkt.rtn_type = `INT_RET;
    wake_pkt.data     = `WAKEUP_DATA;
  end

  always_comb begin
    ret_pkt            = '0;  // Miss, error, way and pfl stay zero
    ret_pkt.valid      = 1'b1;
    ret_pkt.rtn_type   = meta_i.rtn_type;
    ret_pkt.nc         = meta_i.nc;
    ret_pkt.thread     = meta_i.thread;
    ret_pkt.boot_fetch = meta_i.boot_fetch;
    ret_pkt.atomic     = meta_i.atomic;
    ret_pkt.data       = done_data_i.data;
  end

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      wake_pend_q    <= 1'b1;
      spc_ready_o    <= 1'b0;
      spc_packetin_o <= '0;
    end else if (wake_pend_q) begin
      wake_pend_q    <= 1'b0;
      spc_ready_o    <= 1'b1;  // First cycle after reset
      spc_packetin_o <= wake_pkt;
    end else if (done_i) begin
      spc_ready_o    <= 1'b1;
      spc_packetin_o <= ret_pkt;
    end else begin
      spc_ready_o    <= 1'b0;
      spc_packetin_o <= '0;
    end
  end

  // Each return is a single ready pulse
  a_ready_pulse: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    spc_ready_o |=> !spc_ready_o);

endmodule

`default_nettype wire

/* rtl/wb_access/wb_beat_seq.sv */
// Wishbone beat sequencer
// Runs one or two classic single-beat cycles and assembles 128 bits of read data
// Second beat starts one cycle after the first ack
`default_nettype none

`include "spc2wbm_cfg.svh"

module wb_beat_seq (
  input  wire                       sys_clock_i,
  input  wire                       sys_reset_i,
  input  wire                       start_i,
  input  wire wb_bus_pkg::wb_plan_t plan_i,
  input  wire                       wbm_ack_i,
  input  wire [`WB_DATA_W-1:0]      wbm_data_i,
  output wb_bus_pkg::wb_req_t       wbm_req_o,
  output logic                      done_o,
  output wb_bus_pkg::wb_done_t      done_data_o
);

  import wb_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BEAT1,
    ST_GAP,    // Idle cycle between beats
    ST_BEAT2
  } seq_state_t;

  seq_state_t state_q;
  wb_req_t    wb_q;
  wb_done_t   data_q;

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      state_q <= ST_IDLE;
      wb_q    <= '0;      // Bus outputs low after reset
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            wb_q.cyc <= 1'b1;
            wb_q.stb <= 1'b1;
            wb_q.we  <= plan_i.we;
            wb_q.adr <= plan_i.adr1;
            wb_q.dat <= plan_i.dat;
            wb_q.sel <= plan_i.sel1;
            state_q  <= ST_BEAT1;
          end
        end
        ST_BEAT1: begin
          if (wbm_ack_i) begin
            wb_q.cyc <= 1'b0;
            wb_q.stb <= 1'b0;
            if (plan_i.two_beat) begin
              state_q <= ST_GAP;
            end else begin
              done_o  <= 1'b1;
              state_q <= ST_IDLE;
            end
          end
        end
        ST_GAP: begin
          // Second beat is always a full-width read
          wb_q.cyc <= 1'b1;
          wb_q.stb <= 1'b1;
          wb_q.we  <= 1'b0;
          wb_q.adr <= plan_i.adr2;
          wb_q.dat <= '0;
          wb_q.sel <= '1;
          state_q  <= ST_BEAT2;
        end
        ST_BEAT2: begin
          if (wbm_ack_i) begin
            wb_q.cyc <= 1'b0;
            wb_q.stb <= 1'b0;
            done_o   <= 1'b1;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Read data capture, data path only
  always_ff @(posedge sys_clock_i) begin
    if (state_q == ST_BEAT1 && wbm_ack_i) begin
      if (wb_q.we)
        data_q.data <= '0;  // Store ack carries no data
      else if (plan_i.hi_first)
        data_q.data <= {wbm_data_i, {`WB_DATA_W{1'b0}}};
      else
        data_q.data <= {{`WB_DATA_W{1'b0}}, wbm_data_i};
    end else if (state_q == ST_BEAT2 && wbm_ack_i) begin
      data_q.data[`WB_DATA_W-1:0] <= wbm_data_i;  // Odd doubleword
    end
  end

  assign wbm_req_o   = wb_q;
  assign done_data_o = data_q;

  a_stb_cyc: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    wb_q.stb |-> wb_q.cyc);

endmodule

`default_nettype wire

/* rtl/wb_access/wb_access_plan.sv */
// Wishbone access planner
// Turns the latched request into beat addresses, byte selects, write enable
// and the metadata of the return packet
`default_nettype none

`include "spc2wbm_cfg.svh"

module wb_access_plan (
  input  wire pcx_cpx_pkg::pcx_req_t req_i,
  output wb_bus_pkg::wb_plan_t       plan_o,
  output pcx_cpx_pkg::ret_meta_t     meta_o
);

  import pcx_cpx_pkg::*;
  import wb_bus_pkg::*;

  logic [`PCX_ADDR_W-1:0] addr;
  logic [4:0]             rq;
  logic                   is_load;
  logic                   is_store;
  logic                   is_imiss;
  logic [7:0]             size_sel;

  assign addr     = req_i.pkt.addr;
  assign rq       = req_i.pkt.rq_type;
  assign is_load  = (rq == `LOAD_RQ);
  assign is_store = (rq == `STORE_RQ);
  assign is_imiss = (rq == `IMISS_RQ);

  // Byte lanes from size and low address bits
  always_comb begin
    case (req_i.pkt.size)
      `SZ_1B:  size_sel = 8'h01 << addr[2:0];
      `SZ_2B:  size_sel = 8'h03 << {addr[2:1], 1'b0};
      `SZ_4B:  size_sel = 8'h0f << {addr[2], 2'b00};
      `SZ_8B:  size_sel = 8'hff;
      `SZ_16B: size_sel = 8'hff;  // Both beats full width
      default: size_sel = 8'h00;
    endcase
  end

  always_comb begin
    plan_o.we       = is_store;
    // Boot ROM fill reads one 32-bit word on the first beat
    plan_o.sel1     = is_imiss ? (8'h0f << {addr[2], 2'b00}) : size_sel;
    plan_o.adr1     = {req_i.region, 19'b0, addr[`PCX_ADDR_W-1:3], 3'b000};
    plan_o.adr2     = {req_i.region, 19'b0, addr[`PCX_ADDR_W-1:4], 4'b1000};  // Odd doubleword
    plan_o.dat      = req_i.pkt.data;
    plan_o.two_beat = is_imiss || (is_load && req_i.pkt.size == `SZ_16B);
    plan_o.hi_first = ~addr[3];  // Even doubleword goes to data[127:64]
  end

  always_comb begin
    meta_o.rtn_type   = `LOAD_RET;
    meta_o.atomic     = req_i.atomic;
    if (is_imiss) begin
      meta_o.rtn_type = `IFILL_RET;
      meta_o.atomic   = 1'b0;       // Would mean second fill packet
    end else if (is_store) begin
      meta_o.rtn_type = `ST_ACK;
    end
    meta_o.nc         = req_i.pkt.nc;
    meta_o.thread     = req_i.pkt.thread;
    meta_o.boot_fetch = (req_i.region == `REGION_IO);
  end

endmodule

`default_nettype wire

/* rtl/pcx_capture.sv */
// PCX request capture
// Stalls the core on a request, grants it, latches region, atomic bit and packet
`default_nettype none

`include "spc2wbm_cfg.svh"

module pcx_capture (
  input  wire                           sys_clock_i,
  input  wire                           sys_reset_i,
  input  wire [`REGION_W-1:0]           spc_req_i,
  input  wire                           spc_atom_i,
  input  wire pcx_cpx_pkg::pcx_packet_t spc_packetout_i,
  input  wire                           done_i,
  output logic [`REGION_W-1:0]          spc_grant_o,
  output logic                          spc_stallreq_o,
  output logic                          start_o,
  output pcx_cpx_pkg::pcx_req_t         req_o
);

  import pcx_cpx_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GRANT,  // Region latched, packet arrives this cycle
    ST_BUSY    // Access running
  } cap_state_t;

  cap_state_t state_q;
  pcx_req_t   req_q;

  always_ff @(posedge sys_clock_i) begin
    if (sys_reset_i) begin
      state_q        <= ST_IDLE;
      spc_stallreq_o <= 1'b0;
      spc_grant_o    <= '0;
      start_o        <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (|spc_req_i) begin
            spc_stallreq_o <= 1'b1;          // Hold off further requests
            req_q.region   <= spc_req_i;
            req_q.atomic   <= spc_atom_i;
            state_q        <= ST_GRANT;
          end
        end
        ST_GRANT: begin
          req_q.pkt   <= spc_packetout_i;    // Core holds packet one cycle after request
          spc_grant_o <= req_q.region;
          start_o     <= 1'b1;
          state_q     <= ST_BUSY;
        end
        ST_BUSY: begin
          spc_grant_o <= '0;                 // Single-cycle grant
          start_o     <= 1'b0;
          if (done_i) begin
            spc_stallreq_o <= 1'b0;          // Falls with ready
            state_q        <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign req_o = req_q;

  // Packet and start strobe line up, so check the core's request at start
  a_rq_type: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    start_o |-> req_q.pkt.valid && (req_q.pkt.rq_type inside {`LOAD_RQ, `STORE_RQ, `IMISS_RQ}));

  a_imiss_io: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    start_o && req_q.pkt.rq_type == `IMISS_RQ |-> req_q.region == `REGION_IO);

  a_16b_load: assert property (@(posedge sys_clock_i) disable iff (sys_reset_i)
    start_o && req_q.pkt.size == `SZ_16B |-> req_q.pkt.rq_type == `LOAD_RQ);

endmodule

`default_nettype wire

/* common/wb_bus_pkg.sv */
// Wishbone-side types
// Master request, access plan and assembled read data
`default_nettype none

package wb_bus_pkg;

  `include "spc2wbm_cfg.svh"

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`WB_ADDR_W-1:0]  adr;
    logic [`WB_DATA_W-1:0]  dat;
    logic [`WB_DATA_W/8-1:0] sel;
  } wb_req_t;

  // Decoded access, one or two beats
  typedef struct packed {
    logic                    we;
    logic [`WB_DATA_W/8-1:0] sel1;      // First beat only
    logic [`WB_ADDR_W-1:0]   adr1;
    logic [`WB_ADDR_W-1:0]   adr2;
    logic [`WB_DATA_W-1:0]   dat;
    logic                    two_beat;
    logic                    hi_first;  // First beat lands in upper half
  } wb_plan_t;

  typedef struct packed {
    logic [2*`WB_DATA_W-1:0] data;
  } wb_done_t;

endpackage

`default_nettype wire

/* common/pcx_cpx_pkg.sv */
// Processor-side types
// PCX request packet, latched request, CPX return packet, return metadata
`default_nettype none

package pcx_cpx_pkg;

  `include "spc2wbm_cfg.svh"

  // PCX packet, 122 bits
  typedef struct packed {
    logic                   valid;
    logic [4:0]             rq_type;
    logic                   nc;       // Non-cacheable
    logic [2:0]             cpu_id;
    logic [1:0]             thread;
    logic                   inv_all;  // Invalidate all
    logic [1:0]             way;      // Replaced L1 way
    logic [2:0]             size;
    logic [`PCX_ADDR_W-1:0] addr;
    logic [63:0]            data;     // Store data
  } pcx_packet_t;

  // Request as held by the capture block
  typedef struct packed {
    logic [`REGION_W-1:0] region;     // One-hot target
    logic                 atomic;
    pcx_packet_t          pkt;
  } pcx_req_t;

  // CPX packet, 145 bits
  typedef struct packed {
    logic         valid;
    logic [3:0]   rtn_type;
    logic         miss;       // L2 miss
    logic [1:0]   err;
    logic         nc;
    logic [1:0]   thread;
    logic         way_valid;
    logic [1:0]   way;        // Replaced L2 way
    logic         boot_fetch;
    logic         atomic;
    logic         pfl;
    logic [127:0] data;
  } cpx_packet_t;

  // Fields of the return packet known from the request
  typedef struct packed {
    logic [3:0] rtn_type;
    logic       nc;
    logic [1:0] thread;
    logic       boot_fetch;
    logic       atomic;
  } ret_meta_t;

endpackage

`default_nettype wire

/* common/spc2wbm_cfg.svh */
// SPC to Wishbone bridge configuration
// Bus widths, PCX/CPX type codes, size codes and wakeup payload
`ifndef SPC2WBM_CFG_SVH
`define SPC2WBM_CFG_SVH

// Bus widths
`define WB_ADDR_W   64
`define WB_DATA_W   64
`define PCX_ADDR_W  40

// Target region, one-hot
`define REGION_W    5
`define REGION_IO   5'b10000  // Boot ROM / I/O block

// PCX request types
`define LOAD_RQ     5'b00000
`define IMISS_RQ    5'b10000
`define STORE_RQ    5'b00001

// CPX return types
`define LOAD_RET    4'b0000
`define IFILL_RET   4'b0001
`define ST_ACK      4'b0100
`define INT_RET     4'b0111

// Access sizes
`define SZ_1B       3'b000
`define SZ_2B       3'b001
`define SZ_4B       3'b010
`define SZ_8B       3'b011
`define SZ_16B      3'b111

`define WAKEUP_DATA 128'h10001  // Data field of the wakeup packet

`endif
